// ==== design/io_settings.svh ====
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// Clock cycles between two scan frames
`define FRAME_DIV       64

// Nixie tube bank geometry
`define ANODE_NUM       10
`define DIGIT_W         4
`define COUNTER_DIGITS  5

// Keyboard matrix
`define KB_COLS         8
`define KB_ROWS         5
`define KB_KEYS         40

// MS6205 character display
`define MS_COLS         16
`define MS_ROWS         16

`endif

// ==== design/ioBusPkg.sv ====
package ioBusPkg;

    // What the shared emulation bus carries in the current cycle
    typedef enum logic [2:0] {
        NONE     = 3'd0,
        CATHODES = 3'd1,
        ANODES   = 3'd2,
        KB_COL   = 3'd3,
        MS_ADDR  = 3'd4,
        MS_DATA  = 3'd5,
        STOP     = 3'd7
    } busPhaseE;

    // IN-12 cathode wiring is not in digit order
    function automatic logic [3:0] in12Pin(input logic [3:0] digit);
        case (digit)
            4'd0: return 4'd1;
            4'd1: return 4'd0;
            4'd2: return 4'd9;
            4'd3: return 4'd8;
            4'd4: return 4'd7;
            4'd5: return 4'd6;
            4'd6: return 4'd5;
            4'd7: return 4'd4;
            4'd8: return 4'd3;
            4'd9: return 4'd2;
            default: return 4'd15; // Blank tube
        endcase
    endfunction

endpackage

// ==== design/displayPkg.sv ====
package displayPkg;

    // One BCD digit of a dekatron counter
    typedef logic [3:0] bcdT;

    typedef struct packed {
        logic [3:0] row;
        logic [3:0] col;
    } cellRcT;

    // MS6205 cell address, seen as a flat index or as row/column
    typedef union packed {
        logic [7:0] linear;
        cellRcT     rc;
    } cellAddrU;

    // Moves the cursor instead of printing
    localparam logic [7:0] CHAR_NL = 8'h0A;

endpackage

// ==== design/scanTimer.sv ====
`include "io_settings.svh"

module scanTimer (
    input  logic       Clk,
    input  logic       rstN,
    input  logic       frameDone,
    output logic       frameTick,
    output logic [3:0] anodeIdx,
    output logic [2:0] kbCol
);

    localparam int unsigned DivW = $clog2(`FRAME_DIV);

    logic [DivW-1:0] divCnt;

    assign frameTick = (divCnt == DivW'(`FRAME_DIV - 1)); // Last cycle of the period

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            divCnt <= '0;
        end else if (frameTick) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // Both scan positions step once per finished frame
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            anodeIdx <= '0;
            kbCol    <= '0;
        end else if (frameDone) begin
            if (anodeIdx == 4'(`ANODE_NUM - 1)) begin
                anodeIdx <= '0;
            end else begin
                anodeIdx <= anodeIdx + 1'b1;
            end
            if (kbCol == 3'(`KB_COLS - 1)) begin
                kbCol <= '0;
            end else begin
                kbCol <= kbCol + 1'b1;
            end
        end
    end

endmodule

// ==== design/ioSequencer.sv ====
module ioSequencer (
    input  logic               Clk,
    input  logic               rstN,
    input  logic               frameTick,
    input  logic               msPending,
    input  logic               msReady,
    output ioBusPkg::busPhaseE phase,
    output logic               in12ClearN,
    output logic               in12WriteAnode,
    output logic               in12WriteCathode,
    output logic               kbWrite,
    output logic               kbRead,
    output logic               msWriteAddrN,
    output logic               msWriteDataN,
    output logic               frameDone
);

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_CLEAR,
        SEQ_CATH,
        SEQ_ANODE,
        SEQ_KBCOL,
        SEQ_KBREAD,
        SEQ_ADDR,
        SEQ_DATA,
        SEQ_STOP
    } seqStateE;

    seqStateE state;
    seqStateE stateNext;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= SEQ_IDLE;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            SEQ_IDLE:   if (frameTick) stateNext = SEQ_CLEAR; // Ticks mid-frame are lost
            SEQ_CLEAR:  stateNext = SEQ_CATH;
            SEQ_CATH:   stateNext = SEQ_ANODE;
            SEQ_ANODE:  stateNext = SEQ_KBCOL;
            SEQ_KBCOL:  stateNext = SEQ_KBREAD;
            SEQ_KBREAD: stateNext = msPending ? SEQ_ADDR : SEQ_STOP;
            SEQ_ADDR:   if (msReady) stateNext = SEQ_DATA; // Stall until display is ready
            SEQ_DATA:   if (msReady) stateNext = SEQ_STOP;
            SEQ_STOP:   stateNext = SEQ_IDLE;
            default:    stateNext = SEQ_IDLE;
        endcase
    end

    always_comb begin
        case (state)
            SEQ_CATH:  phase = ioBusPkg::CATHODES;
            SEQ_ANODE: phase = ioBusPkg::ANODES;
            SEQ_KBCOL: phase = ioBusPkg::KB_COL;
            SEQ_ADDR:  phase = ioBusPkg::MS_ADDR;
            SEQ_DATA:  phase = ioBusPkg::MS_DATA;
            SEQ_STOP:  phase = ioBusPkg::STOP;
            default:   phase = ioBusPkg::NONE;
        endcase
    end

    // Strobes decode straight from the state
    assign in12ClearN       = (state != SEQ_CLEAR);
    assign in12WriteCathode = (state == SEQ_CATH);
    assign in12WriteAnode   = (state == SEQ_ANODE);
    assign kbWrite          = (state == SEQ_KBCOL);
    assign kbRead           = (state == SEQ_KBREAD); // Rows sampled at the end of this cycle
    assign frameDone        = (state == SEQ_STOP);

    // The write strobes only fall in the cycle msReady is seen high
    assign msWriteAddrN = !((state == SEQ_ADDR) && msReady);
    assign msWriteDataN = !((state == SEQ_DATA) && msReady);

endmodule

// ==== design/nixieScan.sv ====
`include "io_settings.svh"

module nixieScan (
    input  logic [3:0]                          anodeIdx,
    input  logic [`COUNTER_DIGITS*`DIGIT_W-1:0] ipCounter,
    input  logic [`COUNTER_DIGITS*`DIGIT_W-1:0] loopCounter,
    input  logic [`COUNTER_DIGITS*`DIGIT_W-1:0] apCounter,
    input  logic [`COUNTER_DIGITS*`DIGIT_W-1:0] dataCounter,
    output logic [7:0]                          cathodeByte
);

    displayPkg::bcdT highDigit;
    displayPkg::bcdT lowDigit;

    // First five anodes show ip/data, the next five loop/ap
    always_comb begin
        highDigit = 4'hF; // Blank outside the scanned range
        lowDigit  = 4'hF;
        for (int i = 0; i < `COUNTER_DIGITS; i++) begin
            if (anodeIdx == 4'(i)) begin
                highDigit = ipCounter[i*`DIGIT_W +: `DIGIT_W];
                lowDigit  = dataCounter[i*`DIGIT_W +: `DIGIT_W];
            end
            if (anodeIdx == 4'(i + `COUNTER_DIGITS)) begin
                highDigit = loopCounter[i*`DIGIT_W +: `DIGIT_W];
                lowDigit  = apCounter[i*`DIGIT_W +: `DIGIT_W];
            end
        end
    end

    assign cathodeByte = {ioBusPkg::in12Pin(highDigit), ioBusPkg::in12Pin(lowDigit)};

endmodule

// ==== design/keyboardScanner.sv ====
`include "io_settings.svh"

module keyboardScanner (
    input  logic                Clk,
    input  logic                rstN,
    input  logic                kbRead,
    input  logic [2:0]          kbCol,
    input  logic [`KB_ROWS-1:0] kbRows,
    output logic [`KB_COLS-1:0] colDrive,
    output logic [`KB_KEYS-1:0] keysState
);

    assign colDrive = `KB_COLS'(1) << kbCol; // One-hot column select

    // Only the driven column is refreshed, the rest hold their last scan
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            keysState <= '0;
        end else if (kbRead) begin
            for (int c = 0; c < `KB_COLS; c++) begin
                if (kbCol == 3'(c)) begin
                    keysState[c*`KB_ROWS +: `KB_ROWS] <= kbRows;
                end
            end
        end
    end

endmodule

// ==== design/ms6205Writer.sv ====
`include "io_settings.svh"

module ms6205Writer (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  charValid,
    input  logic                  dataWritten,
    input  logic [7:0]            charIn,
    output logic                  charAck,
    output logic                  msPending,
    output displayPkg::cellAddrU  cellAddr,
    output logic [7:0]            charOut
);

    logic isNewline;

    assign charAck   = charValid && !msPending; // One-deep holding slot
    assign isNewline = (charIn == displayPkg::CHAR_NL);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            msPending <= 1'b0;
            cellAddr  <= '0;
        end else if (charAck) begin
            if (isNewline) begin
                // Cursor move only, nothing goes to the display
                cellAddr.rc.col <= '0;
                if (cellAddr.rc.row == 4'(`MS_ROWS - 1)) begin
                    cellAddr.rc.row <= '0;
                end else begin
                    cellAddr.rc.row <= cellAddr.rc.row + 1'b1;
                end
            end else begin
                msPending <= 1'b1;
            end
        end else if (msPending && dataWritten) begin
            msPending <= 1'b0;
            if (cellAddr.rc.col == 4'(`MS_COLS - 1)) begin
                cellAddr.rc.col <= '0; // Wrap into next row
                if (cellAddr.rc.row == 4'(`MS_ROWS - 1)) begin
                    cellAddr.rc.row <= '0;
                end else begin
                    cellAddr.rc.row <= cellAddr.rc.row + 1'b1;
                end
            end else begin
                cellAddr.rc.col <= cellAddr.rc.col + 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (charAck) begin
            charOut <= charIn;
        end
    end

endmodule

// ==== design/ioKeyDisplay.sv ====
`include "io_settings.svh"

module ioKeyDisplay (
    input  logic                                Clk,
    input  logic                                rstN,
    input  logic [`COUNTER_DIGITS*`DIGIT_W-1:0] ipCounter,
    input  logic [`COUNTER_DIGITS*`DIGIT_W-1:0] loopCounter,
    input  logic [`COUNTER_DIGITS*`DIGIT_W-1:0] apCounter,
    input  logic [`COUNTER_DIGITS*`DIGIT_W-1:0] dataCounter,
    input  logic [`KB_ROWS-1:0]                 kbRows,
    input  logic [7:0]                          charIn,
    input  logic                                charValid,
    output logic                                charAck,
    input  logic                                msReady,
    output logic                                msWriteAddrN,
    output logic                                msWriteDataN,
    output logic                                in12WriteAnode,
    output logic                                in12WriteCathode,
    output logic                                in12ClearN,
    output logic                                kbWrite,
    output logic                                kbRead,
    output logic [`KB_KEYS-1:0]                 keysState,
    output logic [7:0]                          emulData
);

    logic                 frameTick;
    logic                 frameDone;
    logic [3:0]           anodeIdx;
    logic [2:0]           kbCol;
    logic [7:0]           cathodeByte;
    logic [`KB_COLS-1:0]  colDrive;
    logic                 msPending;
    displayPkg::cellAddrU cellAddr;
    logic [7:0]           charOut;
    ioBusPkg::busPhaseE   phase;

    scanTimer timer (
        .Clk       (Clk),
        .rstN      (rstN),
        .frameDone (frameDone),
        .frameTick (frameTick),
        .anodeIdx  (anodeIdx),
        .kbCol     (kbCol)
    );

    ioSequencer sequencer (
        .Clk              (Clk),
        .rstN             (rstN),
        .frameTick        (frameTick),
        .msPending        (msPending),
        .msReady          (msReady),
        .phase            (phase),
        .in12ClearN       (in12ClearN),
        .in12WriteAnode   (in12WriteAnode),
        .in12WriteCathode (in12WriteCathode),
        .kbWrite          (kbWrite),
        .kbRead           (kbRead),
        .msWriteAddrN     (msWriteAddrN),
        .msWriteDataN     (msWriteDataN),
        .frameDone        (frameDone)
    );

    nixieScan nixie (
        .anodeIdx    (anodeIdx),
        .ipCounter   (ipCounter),
        .loopCounter (loopCounter),
        .apCounter   (apCounter),
        .dataCounter (dataCounter),
        .cathodeByte (cathodeByte)
    );

    keyboardScanner keyboard (
        .Clk       (Clk),
        .rstN      (rstN),
        .kbRead    (kbRead),
        .kbCol     (kbCol),
        .kbRows    (kbRows),
        .colDrive  (colDrive),
        .keysState (keysState)
    );

    ms6205Writer writer (
        .Clk         (Clk),
        .rstN        (rstN),
        .charValid   (charValid),
        .dataWritten (!msWriteDataN), // Data strobe retires the held character
        .charIn      (charIn),
        .charAck     (charAck),
        .msPending   (msPending),
        .cellAddr    (cellAddr),
        .charOut     (charOut)
    );

    // Bus owner follows the sequencer phase
    always_comb begin
        case (phase)
            ioBusPkg::CATHODES: emulData = cathodeByte;
            ioBusPkg::ANODES:   emulData = {4'b0000, anodeIdx};
            ioBusPkg::KB_COL:   emulData = colDrive;
            ioBusPkg::MS_ADDR:  emulData = cellAddr.linear;
            ioBusPkg::MS_DATA:  emulData = charOut;
            default:            emulData = 8'h00; // NONE and STOP
        endcase
    end

endmodule

// ==== verif/tb_ioKeyDisplay.sv ====
`include "io_settings.svh"

module tb_ioKeyDisplay;

    localparam logic [7:0] NewlineCode = 8'h0A;

    logic Clk, rstN, charValid, charAck, msReady, msWriteAddrN, msWriteDataN;
    logic in12WriteAnode, in12WriteCathode, in12ClearN, kbWrite, kbRead;
    logic [19:0] ipCounter, loopCounter, apCounter, dataCounter;
    logic [4:0]  kbRows;
    logic [7:0]  charIn, emulData;
    logic [39:0] keysState;

    byte         opList[$];                        // One entry per record line
    logic [31:0] argA[$], argB[$], argC[$], argD[$];
    logic [79:0] counterSet;                       // ip, loop, ap, data
    logic [4:0]  rowPattern[8];
    logic [7:0]  charQueue[$];
    logic        readyRandom, modelPending;
    logic        prevClearN, prevKbWrite;          // Strobes seen in the previous cycle
    logic [31:0] rngState;
    logic [39:0] modelKeys;
    logic [7:0]  modelChar;
    int unsigned modelAnode, modelCol, modelRow, modelCellCol;
    int unsigned anodeWrites, ackCount, charTotal, frameTotal, cycleCount, cycleLimit;

    ioKeyDisplay UUT (.*);

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // IN-12 cathode wiring
    function automatic logic [3:0] tubePin(input logic [3:0] digit);
        case (digit)
            4'd0: return 4'd1;
            4'd1: return 4'd0;
            4'd2: return 4'd9;
            4'd3: return 4'd8;
            4'd4: return 4'd7;
            4'd5: return 4'd6;
            4'd6: return 4'd5;
            4'd7: return 4'd4;
            4'd8: return 4'd3;
            4'd9: return 4'd2;
            default: return 4'd15; // Tube dark
        endcase
    endfunction

    function automatic logic [7:0] expectedCathodes(input int unsigned anode);
        if (anode < 5) begin
            return {tubePin(ipCounter[anode*4 +: 4]), tubePin(dataCounter[anode*4 +: 4])};
        end
        return {tubePin(loopCounter[(anode-5)*4 +: 4]), tubePin(apCounter[(anode-5)*4 +: 4])};
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "Test run aborted");
    endtask

    task automatic compareValue(input string name, input logic [63:0] got,
                                input logic [63:0] expected);
        if (got !== expected) begin
            failRun($sformatf("MISMATCH at time %0t: %s = %0h, expected %0h",
                              $time, name, got, expected));
        end
    endtask

    task automatic loadTests();
        int          fd;
        string       line;
        logic [31:0] a0, a1, a2, a3;
        fd = $fopen("verif/io_tests.txt", "r");
        if (fd == 0) failRun("Cannot open the test data file verif/io_tests.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue; // Comment or blank line
            {a0, a1, a2, a3} = '0;
            void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h %h", a0, a1, a2, a3));
            opList.push_back(line.getc(0));
            argA.push_back(a0);
            argB.push_back(a1);
            argC.push_back(a2);
            argD.push_back(a3);
            if (line.getc(0) == "W") frameTotal += a0;
            if (line.getc(0) == "C") charTotal += a1;
        end
        $fclose(fd);
    endtask

    task automatic checkCycle();
        compareValue("keysState", 64'(keysState), 64'(modelKeys));
        compareValue("charAck", 64'(charAck), 64'(charValid && !modelPending));
        // Cathodes right after the clear cycle, row read right after the column write
        compareValue("in12WriteCathode", 64'(in12WriteCathode), 64'(!prevClearN));
        compareValue("kbRead", 64'(kbRead), 64'(prevKbWrite));
        if (!msReady) begin // Display busy, no write may start
            compareValue("msWriteAddrN", 64'(msWriteAddrN), 64'd1);
            compareValue("msWriteDataN", 64'(msWriteDataN), 64'd1);
        end
        if (in12WriteCathode) compareValue("emulData", 64'(emulData),
                                           64'(expectedCathodes(modelAnode)));
        if (in12WriteAnode) begin
            compareValue("emulData", 64'(emulData), 64'(modelAnode));
            modelAnode = (modelAnode + 1) % `ANODE_NUM;
            anodeWrites++;
        end
        if (kbWrite) compareValue("emulData", 64'(emulData), 64'(8'd1 << modelCol));
        if (kbRead) begin // Rows land in keysState at the coming edge
            modelKeys[modelCol*`KB_ROWS +: `KB_ROWS] = rowPattern[3'(modelCol)];
            modelCol = (modelCol + 1) % `KB_COLS;
        end
        if (charAck) begin
            ackCount++;
            if (charQueue[0] == NewlineCode) begin
                modelCellCol = 0;
                modelRow     = (modelRow + 1) % `MS_ROWS;
            end else begin
                modelPending = 1'b1;
                modelChar    = charQueue[0];
            end
            void'(charQueue.pop_front());
        end
        if (!msWriteAddrN) begin
            compareValue("charPending", 64'(modelPending), 64'd1);
            compareValue("emulData", 64'(emulData), 64'(modelRow * `MS_COLS + modelCellCol));
        end
        if (!msWriteDataN) begin
            compareValue("charPending", 64'(modelPending), 64'd1);
            compareValue("emulData", 64'(emulData), 64'(modelChar));
            modelPending = 1'b0;
            if (modelCellCol == `MS_COLS - 1) begin
                modelCellCol = 0; // Wrap to next row
                modelRow     = (modelRow + 1) % `MS_ROWS;
            end else begin
                modelCellCol++;
            end
        end
        prevClearN  = in12ClearN;
        prevKbWrite = kbWrite;
    endtask

    task automatic stepCycle();
        @(negedge Clk);
        {ipCounter, loopCounter, apCounter, dataCounter} = counterSet;
        kbRows    = rowPattern[3'(modelCol)];
        charValid = (charQueue.size() != 0);
        if (charValid) charIn = charQueue[0];
        else charIn = 8'h00;
        if (readyRandom) begin
            rngState = xorshift32(rngState);
            msReady  = (rngState[1:0] != 2'b00); // Busy about one cycle in four
        end else begin
            msReady = 1'b1;
        end
        #1;
        cycleCount++;
        if (cycleCount > cycleLimit) failRun("Timeout: the tests did not finish in time");
        checkCycle();
    endtask

    task automatic waitFrames(input int unsigned frames);
        int unsigned target;
        target = anodeWrites + frames;
        while (anodeWrites < target) stepCycle();
    endtask

    initial begin
        rstN = 1'b0;
        {ipCounter, loopCounter, apCounter, dataCounter, counterSet} = '0;
        {kbRows, charIn, charValid, msReady, readyRandom, modelPending} = '0;
        prevClearN  = 1'b1;
        prevKbWrite = 1'b0;
        foreach (rowPattern[c]) rowPattern[c] = '0;
        {modelKeys, modelChar} = '0;
        {modelAnode, modelCol, modelRow, modelCellCol} = '0;
        {anodeWrites, ackCount, charTotal, frameTotal, cycleCount} = '0;
        rngState = 32'h6bfa9f47;
        loadTests();
        cycleLimit = (frameTotal + charTotal) * `FRAME_DIV * 2;
        repeat (16) @(negedge Clk);
        rstN = 1'b1;
        #1;
        compareValue("high strobes", 64'({in12WriteAnode, in12WriteCathode, kbWrite, kbRead}),
                     64'd0);
        compareValue("low strobes", 64'({in12ClearN, msWriteAddrN, msWriteDataN}), 64'h7);
        compareValue("keysState", 64'(keysState), 64'd0);
        compareValue("charAck", 64'(charAck), 64'd0);
        foreach (opList[i]) begin
            case (opList[i])
                "D": counterSet = {argA[i][19:0], argB[i][19:0], argC[i][19:0], argD[i][19:0]};
                "K": rowPattern[3'(argA[i])] = 5'(argB[i]);
                "C": for (int k = 0; k < int'(argB[i]); k++) begin
                    charQueue.push_back(8'(argA[i] + 32'(k)));
                end
                "R": readyRandom = argA[i][0];
                "W": waitFrames(argA[i]);
                default: failRun("Unknown record type in the test data file");
            endcase
        end
        while (charQueue.size() != 0 || modelPending) stepCycle(); // Let queued chars drain
        compareValue("charAck count", 64'(ackCount), 64'(charTotal));
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verif/io_tests.txt ====
# Records, all numbers hex: D ip loop ap data | K col rows | C firstChar count
# R randomReady (0 ready, 1 xorshift) | W frames
R 0
D 01234 56789 0a0f3 98765
K 0 15
K 1 0a
K 2 1f
K 3 00
K 4 11
K 5 04
K 6 1b
K 7 0e
W 0c
C 41 2
C 0a 1
C 43 1
W 6
K 3 1c
K 6 03
D 13579 24680 11111 90909
W a
R 1
C 30 12
W 20
C 0a 2
C 61 3
W 8

// ==== project.f ====
+incdir+design
design/ioBusPkg.sv
design/displayPkg.sv
design/scanTimer.sv
design/ioSequencer.sv
design/nixieScan.sv
design/keyboardScanner.sv
design/ms6205Writer.sv
design/ioKeyDisplay.sv
verif/tb_ioKeyDisplay.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_ioKeyDisplay -f project.f -o simIoKeyDisplay \
    && ./obj_dir/simIoKeyDisplay || exit 1
